//--- sim/ocyrus_tests.txt
// one step per word, fields op_lane_word1_word2_mask in hex
// op 1 write, 2 two writes to one lane, 3 read and compare mask, 4 wait for word_mark, 0 end
// first frames after reset are idle on every lane
4_0_00_00_00
4_0_00_00_00
// a word on lanes 0 to 2 in one frame, lane 3 lands one frame later
1_0_a5_00_00
1_1_3c_00_00
1_2_f0_00_00
3_0_00_00_07
1_3_81_00_00
// mask is clear once the strobe has passed
4_0_00_00_00
3_0_00_00_00
// lanes 1 and 3 only, the others send idle
4_0_00_00_00
1_1_c3_00_00
1_3_5a_00_00
3_0_00_00_0a
// two words into lane 1, second waits for the frame boundary
4_0_00_00_00
2_1_11_22_00
3_0_00_00_02
// lane 2 staged next to a double write on lane 0
4_0_00_00_00
1_2_e7_00_00
2_0_96_69_00
3_0_00_00_01
// plain write into a busy lane stalls the bus
4_0_00_00_00
1_3_01_00_00
1_3_80_00_00
1_0_ff_00_00
3_0_00_00_09
// all ones everywhere, then idle frames
4_0_00_00_00
1_0_ff_00_00
1_1_ff_00_00
1_2_ff_00_00
1_3_ff_00_00
4_0_00_00_00
4_0_00_00_00
// alternating patterns
1_0_55_00_00
1_1_aa_00_00
1_2_55_00_00
1_3_aa_00_00
4_0_00_00_00
3_0_00_00_00
// walking ones
1_0_01_00_00
1_1_02_00_00
1_2_04_00_00
1_3_08_00_00
4_0_00_00_00
0_0_00_00_00

//--- ocyrus.f
common/ocyrus_pkg.sv
common/ocyrus_wb_pkg.sv
design/serdes_strobe_gen.sv
design/wb_word_stage.sv
design/lane_serializer.sv
design/lane_output_delay.sv
design/ocyrus_quad_tx.sv
sim/ocyrus_quad_tx_tb.sv

//--- Bender.yml
package:
  name: ocyrus

sources:
  # shared packages
  - common/ocyrus_pkg.sv
  - common/ocyrus_wb_pkg.sv
  # rtl
  - design/serdes_strobe_gen.sv
  - design/wb_word_stage.sv
  - design/lane_serializer.sv
  - design/lane_output_delay.sv
  - design/ocyrus_quad_tx.sv
  # testbench
  - target: simulation
    files:
      - sim/ocyrus_quad_tx_tb.sv

//--- sim/ocyrus_quad_tx_tb.sv
module ocyrus_quad_tx_tb
	import ocyrus_pkg::*, ocyrus_wb_pkg::*;
;

	localparam int MAX_STEPS = 128; // room in the step memory

	logic       bit_clock;
	logic       rst_n;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	wb_addr_t   wb_adr;
	wb_data_t   wb_dat_w;
	wb_data_t   wb_dat_r;
	logic       wb_ack;
	lane_mask_t d_out;
	logic       word_mark;
	logic       locked;

	logic [31:0] step_mem [MAX_STEPS]; // op, lane, word1, word2, mask
	int          step_count; // steps before the end marker

	// posedge copies of the bus request, lined up with the ack cycle
	logic     running; // reset released, monitor active
	int       post_count; // clocks since reset release
	logic     req_we_q;
	wb_addr_t req_adr_q;
	wb_data_t req_dat_q;

	// model of the next frame and of what has been seen on the lines
	lane_mask_t  model_pend; // lanes acked since the last mark
	tx_word_t    model_word [NUM_LANES];
	logic [31:0] frame_q [$]; // expected words, lane n in bits n*8 +: 8
	int          mark_at_q [$]; // cycle of each word_mark
	int          lane_frame [NUM_LANES]; // next frame to collect per lane
	int          lane_bits [NUM_LANES]; // bits collected so far
	tx_word_t    lane_col [NUM_LANES]; // bits as they come in, msb first

	ocyrus_quad_tx ocyrus_quad_tx_i (
		.bit_clock (bit_clock),
		.rst_n     (rst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.d_out     (d_out),
		.word_mark (word_mark),
		.locked    (locked)
	);

	always #2 bit_clock = ~bit_clock; // period 4

	// lane skew in bit clocks, 0 2 5 6
	function automatic int expected_delay(input int lane);
		case (lane)
			0: return 0;
			1: return 2;
			2: return 5;
			default: return 6;
		endcase
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	// call on a falling edge, returns on the falling edge after the ack edge
	task automatic bus_transfer(input logic we, input wb_addr_t adr, input wb_data_t dat,
		output wb_data_t rdata, output logic saw_mark);
		saw_mark = 1'b0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		do begin
			@(negedge bit_clock);
			if (word_mark) begin
				saw_mark = 1'b1; // frame boundary passed while waiting
			end
		end while (wb_ack !== 1'b1);
		rdata = wb_dat_r;
		@(negedge bit_clock); // request stays up through the edge that takes the ack
		check_value("wb_ack after one cycle", wb_ack, 1'b0);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wait_word_mark();
		do begin
			@(negedge bit_clock);
		end while (word_mark !== 1'b1);
	endtask

	always @(posedge bit_clock) begin
		running   <= rst_n;
		req_we_q  <= wb_we; // inputs only move on the falling edge
		req_adr_q <= wb_adr;
		req_dat_q <= wb_dat_w;
		if (!rst_n) begin
			post_count <= 0;
		end else begin
			post_count <= post_count + 1;
		end
	end

	// outputs are settled half a period after the rising edge
	always @(negedge bit_clock) begin : line_monitor
		int          cyc;
		logic [31:0] word_pack;
		tx_word_t    exp_word;
		if (running) begin
			cyc = post_count;
			check_value("word_mark", word_mark, (cyc >= BIT_DEPTH) && (cyc % BIT_DEPTH == 0));
			check_value("locked", locked, cyc >= BIT_DEPTH);
			if (word_mark) begin
				for (int n = 0; n < NUM_LANES; n++) begin
					word_pack[n*8 +: 8] = model_pend[n] ? model_word[n] : IDLE_WORD;
				end
				frame_q.push_back(word_pack); // frame starts now
				mark_at_q.push_back(cyc);
				model_pend = '0;
			end
			// ack in a mark cycle belongs to the following frame
			if (wb_ack && req_we_q) begin
				model_pend[req_adr_q] = 1'b1;
				model_word[req_adr_q] = req_dat_q;
			end
			for (int n = 0; n < NUM_LANES; n++) begin
				if (lane_frame[n] < frame_q.size()) begin
					if (cyc >= mark_at_q[lane_frame[n]] + expected_delay(n)) begin
						lane_col[n] = {lane_col[n][BIT_DEPTH-2:0], d_out[n]};
						lane_bits[n]++;
						if (lane_bits[n] == BIT_DEPTH) begin
							word_pack = frame_q[lane_frame[n]];
							exp_word  = word_pack[n*8 +: 8];
							check_value($sformatf("d_out[%0d] word", n), lane_col[n], exp_word);
							lane_frame[n]++;
							lane_bits[n] = 0;
						end
					end
				end
			end
		end
	end

	// watchdog, 40 clocks per step plus slack for the last frames
	initial begin
		wait (step_count > 0);
		repeat (step_count * 40 + 100) @(posedge bit_clock);
		stop_with_failure($sformatf("Timeout: %0d test steps did not finish in time", step_count));
	end

	initial begin : step_runner
		logic [31:0] step;
		logic [3:0]  op;
		wb_addr_t    lane;
		wb_data_t    rdata;
		logic        saw_mark;
		bit_clock  = 1'b0;
		rst_n      = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		running    = 1'b0;
		post_count = 0;
		model_pend = '0;
		for (int n = 0; n < NUM_LANES; n++) begin
			model_word[n] = IDLE_WORD;
			lane_frame[n] = 0;
			lane_bits[n]  = 0;
			lane_col[n]   = '0;
		end
		for (int i = 0; i < MAX_STEPS; i++) begin
			step_mem[i] = '0; // op 0 marks the end
		end
		$readmemh("sim/ocyrus_tests.txt", step_mem);
		step_count = 0;
		while (step_count < MAX_STEPS && step_mem[step_count][31:28] != 4'h0) begin
			step_count++;
		end
		if (step_count == 0) begin
			stop_with_failure("no test steps could be read from sim/ocyrus_tests.txt");
		end

		repeat (3) @(posedge bit_clock); // reset held for 3 cycles
		@(negedge bit_clock);
		check_value("wb_ack", wb_ack, 1'b0);
		check_value("locked", locked, 1'b0);
		check_value("word_mark", word_mark, 1'b0);
		check_value("d_out", d_out, '0);
		rst_n = 1'b1;

		for (int i = 0; i < step_count; i++) begin
			step = step_mem[i];
			op   = step[31:28];
			lane = wb_addr_t'(step[27:24]);
			case (op)
				4'h1: bus_transfer(1'b1, lane, step[23:16], rdata, saw_mark);
				4'h2: begin
					bus_transfer(1'b1, lane, step[23:16], rdata, saw_mark);
					bus_transfer(1'b1, lane, step[15:8], rdata, saw_mark); // held off by pending
					check_value("word_mark before second ack", saw_mark, 1'b1);
				end
				4'h3: begin
					bus_transfer(1'b0, lane, '0, rdata, saw_mark);
					check_value("wb_dat_r", rdata, step[7:0]); // pending mask
				end
				4'h4: wait_word_mark();
				default: stop_with_failure($sformatf("unknown step code %h in step %0d", op, i));
			endcase
		end

		repeat (3) wait_word_mark(); // flush the staged words through the delays
		repeat (MAX_DELAY_TAPS + BIT_DEPTH) @(negedge bit_clock); // longest lane finishes its word
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- design/ocyrus_quad_tx.sv
module ocyrus_quad_tx
	import ocyrus_pkg::*, ocyrus_wb_pkg::*;
(
	input  logic       bit_clock, // serial bit rate clock
	input  logic       rst_n,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  wb_addr_t   wb_adr, // lane number on writes
	input  wb_data_t   wb_dat_w,
	output wb_data_t   wb_dat_r,
	output logic       wb_ack,
	output lane_mask_t d_out, // one serial line per lane
	output logic       word_mark, // start of word, before lane delays
	output logic       locked // strobe generator running
);

	logic       load_strobe; // frame boundary, every BIT_DEPTH clocks
	lane_mask_t pending; // lanes with a word waiting
	tx_word_t   staged_words [NUM_LANES];
	lane_mask_t serial_bits; // serializer to delay lines

	// replaces the pll and io clock buffer strobe
	serdes_strobe_gen serdes_strobe_gen_i (
		.bit_clock   (bit_clock),
		.rst_n       (rst_n),
		.load_strobe (load_strobe),
		.locked      (locked)
	);

	// bus side, one staging register per lane
	wb_word_stage wb_word_stage_i (
		.bit_clock    (bit_clock),
		.rst_n        (rst_n),
		.load_strobe  (load_strobe),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.pending      (pending),
		.staged_words (staged_words)
	);

	// 8:1 shift out, msb first
	lane_serializer lane_serializer_i (
		.bit_clock    (bit_clock),
		.rst_n        (rst_n),
		.load_strobe  (load_strobe),
		.pending      (pending),
		.staged_words (staged_words),
		.serial_bits  (serial_bits),
		.word_mark    (word_mark)
	);

	// fixed per-lane skew, stands in for the output delay taps
	lane_output_delay lane_output_delay_i (
		.bit_clock   (bit_clock),
		.rst_n       (rst_n),
		.serial_bits (serial_bits),
		.d_out       (d_out)
	);

endmodule

//--- design/lane_output_delay.sv
module lane_output_delay
	import ocyrus_pkg::*;
(
	input  logic       bit_clock,
	input  logic       rst_n,
	input  lane_mask_t serial_bits, // undelayed lane bits
	output lane_mask_t d_out // each lane late by LANE_DELAY[n]
);

	for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
		localparam int TAPS = int'(LANE_DELAY[n]);

		if (TAPS == 0) begin : g_direct
			assign d_out[n] = serial_bits[n]; // zero delay, no flops
		end else begin : g_chain
			logic [MAX_DELAY_TAPS-1:0] chain_q; // bit 0 is one clock late

			always_ff @(posedge bit_clock) begin
				if (!rst_n) begin
					chain_q <= '0;
				end else begin
					chain_q <= {chain_q[MAX_DELAY_TAPS-2:0], serial_bits[n]};
				end
			end

			assign d_out[n] = chain_q[TAPS-1]; // tap at the lane delay
		end

		// table entries beyond the chain length would tap past its end
		a_delay_in_range: assert property (
			@(posedge bit_clock)
			$rose(rst_n) |-> (LANE_DELAY[n] <= MAX_DELAY_TAPS)
		);
	end

endmodule

//--- design/lane_serializer.sv
module lane_serializer
	import ocyrus_pkg::*;
(
	input  logic       bit_clock,
	input  logic       rst_n,
	input  logic       load_strobe, // parallel load point
	input  lane_mask_t pending, // lanes with a staged word
	input  tx_word_t   staged_words [NUM_LANES],
	output lane_mask_t serial_bits, // msb of each shift register
	output logic       word_mark // bit 7 is on serial_bits this cycle
);

	tx_word_t shift_q [NUM_LANES]; // one parallel-load shift register per lane
	logic     mark_q;

	// load on the strobe, shift left otherwise
	// pending is taken as is, the staging side clears it on the same edge
	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			for (int n = 0; n < NUM_LANES; n++) begin
				shift_q[n] <= '0; // keeps the lines quiet out of reset
			end
		end else if (load_strobe) begin
			for (int n = 0; n < NUM_LANES; n++) begin
				if (pending[n]) begin
					shift_q[n] <= staged_words[n];
				end else begin
					shift_q[n] <= IDLE_WORD; // nothing written for this frame
				end
			end
		end else begin
			for (int n = 0; n < NUM_LANES; n++) begin
				shift_q[n] <= {shift_q[n][BIT_DEPTH-2:0], 1'b0}; // msb first
			end
		end
	end

	// serial bit comes straight off the register msb
	always_comb begin
		for (int n = 0; n < NUM_LANES; n++) begin
			serial_bits[n] = shift_q[n][BIT_DEPTH-1];
		end
	end

	// strobe delayed by one, lines up with bit 7 of the new word
	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			mark_q <= 1'b0;
		end else begin
			mark_q <= load_strobe;
		end
	end

	assign word_mark = mark_q;

endmodule

//--- design/wb_word_stage.sv
module wb_word_stage
	import ocyrus_pkg::*, ocyrus_wb_pkg::*;
(
	input  logic       bit_clock,
	input  logic       rst_n,
	input  logic       load_strobe, // frame boundary, clears all pending
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  wb_addr_t   wb_adr, // lane select
	input  wb_data_t   wb_dat_w,
	output wb_data_t   wb_dat_r, // pending mask on reads
	output logic       wb_ack, // registered, one cycle per transfer
	output lane_mask_t pending, // lanes holding a word for next frame
	output tx_word_t   staged_words [NUM_LANES]
);

	logic     bus_req; // a new transfer is waiting
	logic     wr_accept; // write goes into a free lane this cycle
	logic     rd_accept; // status read this cycle
	logic     ack_q;
	wb_data_t rd_data_q;
	lane_mask_t pending_q;
	tx_word_t stage_q [NUM_LANES]; // one staging register per lane

	// the !ack_q term keeps a held request from being acked twice
	assign bus_req = wb_cyc && wb_stb && !ack_q;

	// a busy lane simply leaves the master waiting, that is the back-pressure
	assign wr_accept = bus_req && wb_we && !pending_q[wb_adr];
	assign rd_accept = bus_req && !wb_we;

	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= wr_accept || rd_accept; // one cycle after the accept
		end
	end

	// pending flags
	// a strobe empties every lane at once
	// a write accepted in the strobe edge still sets its bit,
	// so the word lands in the frame after this one
	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			pending_q <= '0;
		end else begin
			if (load_strobe) begin
				pending_q <= '0;
			end
			if (wr_accept) begin
				pending_q[wb_adr] <= 1'b1; // set wins over the strobe clear
			end
		end
	end

	// word payload, only meaningful while the pending bit is up
	always_ff @(posedge bit_clock) begin
		if (wr_accept) begin
			stage_q[wb_adr] <= tx_word_t'(wb_dat_w);
		end
	end

	// read data sampled with the request, presented with the ack
	always_ff @(posedge bit_clock) begin
		if (rd_accept) begin
			rd_data_q <= wb_data_t'(pending_q); // zero extended mask
		end
	end

	assign wb_ack       = ack_q;
	assign wb_dat_r     = rd_data_q;
	assign pending      = pending_q;
	assign staged_words = stage_q;

	// ack must only answer a live cycle, master holds cyc/stb until it sees ack
	a_ack_in_cycle: assert property (
		@(posedge bit_clock) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb)
	);

endmodule

//--- design/serdes_strobe_gen.sv
module serdes_strobe_gen
	import ocyrus_pkg::*;
(
	input  logic bit_clock,
	input  logic rst_n,
	output logic load_strobe, // one cycle in every BIT_DEPTH
	output logic locked // high from the cycle after the first strobe
);

	localparam strobe_count_t LAST_COUNT = strobe_count_t'(BIT_DEPTH - 1);

	strobe_count_t bit_count; // position of the current bit in the word
	logic seen_strobe; // first strobe has gone out

	// plain divide by BIT_DEPTH, stands in for the io clock buffer strobe
	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			bit_count <= '0;
		end else if (bit_count == LAST_COUNT) begin
			bit_count <= '0; // wrap at word boundary
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	assign load_strobe = (bit_count == LAST_COUNT); // 8th cycle after reset release

	always_ff @(posedge bit_clock) begin
		if (!rst_n) begin
			seen_strobe <= 1'b0;
		end else if (load_strobe) begin
			seen_strobe <= 1'b1; // sticky until reset
		end
	end

	assign locked = seen_strobe;

	// word framing depends on strobes being isolated single pulses
	a_strobe_single: assert property (
		@(posedge bit_clock) disable iff (!rst_n)
		load_strobe |=> !load_strobe
	);

endmodule

//--- common/ocyrus_wb_pkg.sv
package ocyrus_wb_pkg;

	// bus widths
	localparam int WB_ADDR_WIDTH = 2; // one address per lane
	localparam int WB_DATA_WIDTH = 8; // one word per transfer

	// address map
	// write to address n stages the word for lane n
	// read at any address gives the pending mask in the low bits,
	// upper bits read as zero
	typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;

	// bus data, same width as a lane word
	typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

endpackage

//--- common/ocyrus_pkg.sv
package ocyrus_pkg;

	// lane geometry
	localparam int NUM_LANES = 4; // serial outputs driven in parallel
	localparam int BIT_DEPTH = 8; // bit clocks per word, 8:1 serializing

	// output delay limit
	// taps above 6 cost full bit rate on the vendor odelay primitive,
	// so the portable delay line keeps the same ceiling
	localparam int MAX_DELAY_TAPS = 6;

	// one lane word, sent msb first
	typedef logic [BIT_DEPTH-1:0] tx_word_t;

	// one bit per lane, used for pending flags and serial bits
	typedef logic [NUM_LANES-1:0] lane_mask_t;

	// an amount of output delay in bit clocks, 0 to 7
	typedef logic [2:0] delay_count_t;

	// bit position inside a word, wraps at BIT_DEPTH
	typedef logic [$clog2(BIT_DEPTH)-1:0] strobe_count_t;

	// fixed per-lane output delay in bit clocks
	localparam delay_count_t LANE_DELAY [NUM_LANES] = '{
		3'd0, // lane 0 straight through
		3'd2, // lane 1
		3'd5, // lane 2
		3'd6  // lane 3 at the tap limit
	};

	// word sent on a lane that had nothing staged for the frame
	localparam tx_word_t IDLE_WORD = 8'h00;

endpackage
